// ==== Bender.yml ====
package:
  name: ex_top

sources:
  - design/ex_pkg.sv
  - design/ex_alu.sv
  - design/ex_mult.sv
  - design/ex_issue.sv
  - design/ex_stage.sv
  - design/ex_wb_stage.sv
  - design/ex_top.sv
  - target: simulation
    files:
      - testbench/ex_top_asserts.sv
      - testbench/tb_ex_top.sv

// ==== design/ex_alu.sv ====
`timescale 1ns/10ps

module ex_alu
(
  input  logic          enable_i,
  input  ex_pkg::op_e   operator_i,
  input  ex_pkg::word_t operand_a_i,
  input  ex_pkg::word_t operand_b_i,
  output ex_pkg::word_t result_o,
  output logic          comparison_result_o
);
  import ex_pkg::*;

  logic       is_sub;
  word_t      adder_b;
  word_t      adder_result;
  logic [4:0] shamt;
  logic       is_equal;
  logic       lt_signed;
  logic       lt_unsigned;

  //////////////////////////////////////////////////
  // Shared adder
  //////////////////////////////////////////////////

  // Subtract as a + ~b + 1
  assign is_sub       = (operator_i == SUB);
  assign adder_b      = is_sub ? ~operand_b_i : operand_b_i;
  assign adder_result = operand_a_i + adder_b + word_t'(is_sub);

  // Shift amount is the low 5 bits of b
  assign shamt = operand_b_i[4:0];

  // Comparators, shared by SLT and the branches
  assign is_equal    = (operand_a_i == operand_b_i);
  assign lt_signed   = ($signed(operand_a_i) < $signed(operand_b_i));
  assign lt_unsigned = (operand_a_i < operand_b_i);

  //////////////////////////////////////////////////
  // Result mux
  //////////////////////////////////////////////////

  always_comb
  begin
    result_o = '0;
    // Idle ALU keeps its outputs quiet
    if (enable_i)
    begin
      case (operator_i)
        ADD, SUB: result_o = adder_result;
        AND:      result_o = operand_a_i & operand_b_i;
        OR:       result_o = operand_a_i | operand_b_i;
        XOR:      result_o = operand_a_i ^ operand_b_i;
        SLL:      result_o = operand_a_i << shamt;
        SRL:      result_o = operand_a_i >> shamt;
        SRA:      result_o = $signed(operand_a_i) >>> shamt;
        SLT:      result_o = word_t'(lt_signed);
        SLTU:     result_o = word_t'(lt_unsigned);
        default:  result_o = '0;
      endcase
    end
  end

  // Branch condition
  always_comb
  begin
    comparison_result_o = 1'b0;
    if (enable_i)
    begin
      case (operator_i)
        BEQ:     comparison_result_o = is_equal;
        BNE:     comparison_result_o = !is_equal;
        BLT:     comparison_result_o = lt_signed;
        BGE:     comparison_result_o = !lt_signed;
        default: comparison_result_o = 1'b0;
      endcase
    end
  end

endmodule

// ==== design/ex_issue.sv ====
`timescale 1ns/10ps

module ex_issue
(
  input  logic              clk,
  input  logic              rst_n,

  // Instruction from the outside
  input  ex_pkg::instr_t    instr_i,
  input  logic              instr_valid_i,
  output logic              issue_ready_o,

  // Stall from EX
  input  logic              ex_ready_i,

  // Forwarding sources
  input  ex_pkg::fwd_t      fwd_ex_i,
  input  ex_pkg::fwd_t      fwd_wb_i,

  // Register file read ports
  output ex_pkg::reg_addr_t rf_raddr_a_o,
  output ex_pkg::reg_addr_t rf_raddr_b_o,
  input  ex_pkg::word_t     rf_rdata_a_i,
  input  ex_pkg::word_t     rf_rdata_b_i,

  output ex_pkg::id_ex_pipe_t id_ex_pipe_o
);
  import ex_pkg::*;

  logic        is_mult;
  logic        is_branch;
  word_t       rs1_data;
  word_t       rs2_data;
  id_ex_pipe_t id_ex_d;

  // EX result wins over WB, WB over the file, x0 never forwards
  function automatic word_t fwd_sel(reg_addr_t addr, word_t rf_data, fwd_t ex_src,
                                    fwd_t wb_src);
    if (addr == '0)
      return '0;
    if (ex_src.we && (ex_src.waddr == addr))
      return ex_src.wdata;
    if (wb_src.we && (wb_src.waddr == addr))
      return wb_src.wdata;
    return rf_data;
  endfunction

  // Issue is accepted whenever EX can take a new instruction
  assign issue_ready_o = ex_ready_i;

  // Register file is read in the issue cycle
  assign rf_raddr_a_o = instr_i.rs1;
  assign rf_raddr_b_o = instr_i.rs2;

  assign rs1_data = fwd_sel(instr_i.rs1, rf_rdata_a_i, fwd_ex_i, fwd_wb_i);
  assign rs2_data = fwd_sel(instr_i.rs2, rf_rdata_b_i, fwd_ex_i, fwd_wb_i);

  // Decode into unit enables and operands
  always_comb
  begin
    is_mult   = instr_i.op inside {MUL, MULH, MULHU};
    is_branch = instr_i.op inside {BEQ, BNE, BLT, BGE};

    id_ex_d.valid     = instr_valid_i;
    id_ex_d.op        = instr_i.op;
    id_ex_d.rd        = instr_i.rd;
    id_ex_d.operand_a = rs1_data;
    // Branches compare rs1 against rs2, imm is only the target
    id_ex_d.operand_b = (instr_i.use_imm && !is_branch) ? instr_i.imm : rs2_data;
    id_ex_d.target    = instr_i.imm;

    // Control bits only set for a real instruction
    id_ex_d.alu_en       = instr_valid_i && !is_mult && !is_branch;
    id_ex_d.mult_en      = instr_valid_i && is_mult;
    id_ex_d.branch_in_ex = instr_valid_i && is_branch;
    // Writes to x0 are dropped here
    id_ex_d.rf_we        = instr_valid_i && !is_branch && (instr_i.rd != '0);
  end

  // ID/EX register, holds while EX stalls
  always_ff @(posedge clk, negedge rst_n)
  begin : id_ex_register
    if (!rst_n)
      id_ex_pipe_o <= '0;
    else if (ex_ready_i)
      id_ex_pipe_o <= id_ex_d;
  end

endmodule

// ==== design/ex_mult.sv ====
`timescale 1ns/10ps

module ex_mult
#(
  parameter int unsigned MultBitsPerCycle = 2
)
(
  input  logic          clk,
  input  logic          rst_n,
  input  logic          enable_i,
  input  ex_pkg::op_e   operator_i,
  input  ex_pkg::word_t op_a_i,
  input  ex_pkg::word_t op_b_i,
  input  logic          ex_ready_i,
  output ex_pkg::word_t result_o,
  output logic          ready_o
);
  import ex_pkg::*;

  // Iterations per multiply, first one done in the start cycle
  localparam int unsigned num_steps = 32 / MultBitsPerCycle;
  localparam int unsigned cnt_w     = $clog2(num_steps);

  typedef enum logic [1:0] {IDLE, BUSY, DONE} mult_state_e;

  mult_state_e                   state_q;
  logic [cnt_w-1:0]              cnt_q;
  logic                          signed_mode;
  logic                          neg_result;
  word_t                         mag_a;
  word_t                         mag_b;
  word_t                         step_hi;
  word_t                         step_lo;
  logic [31+MultBitsPerCycle:0]  partial;
  logic [31+MultBitsPerCycle:0]  sum;
  logic [63:0]                   prod_d;
  logic [63:0]                   prod_q;
  logic [63:0]                   product;

  // Only MULH needs signed operands, the low half does not care
  assign signed_mode = (operator_i == MULH);
  assign mag_a       = (signed_mode && op_a_i[31]) ? -op_a_i : op_a_i;
  assign mag_b       = (signed_mode && op_b_i[31]) ? -op_b_i : op_b_i;
  assign neg_result  = signed_mode && (op_a_i[31] ^ op_b_i[31]);

  // One shift-add step, {hi, lo} with the multiplier in lo
  always_comb
  begin
    if (state_q == IDLE)
    begin
      step_hi = '0;
      step_lo = mag_b;
    end
    else
    begin
      step_hi = prod_q[63:32];
      step_lo = prod_q[31:0];
    end
    partial = mag_a * step_lo[MultBitsPerCycle-1:0];
    sum     = partial + step_hi;
    prod_d  = {sum, step_lo[31:MultBitsPerCycle]};
  end

  always_ff @(posedge clk)
  begin
    if ((state_q == IDLE && enable_i) || state_q == BUSY)
      prod_q <= prod_d;
  end

  // Control FSM
  always_ff @(posedge clk, negedge rst_n)
  begin
    if (!rst_n)
    begin
      state_q <= IDLE;
      cnt_q   <= '0;
    end
    else
    begin
      case (state_q)
        IDLE:
        begin
          if (enable_i)
          begin
            state_q <= BUSY;
            cnt_q   <= cnt_w'(num_steps - 1);
          end
        end
        BUSY:
        begin
          cnt_q <= cnt_q - 1'b1;
          if (cnt_q == cnt_w'(1))
            state_q <= DONE;
        end
        // Hold the result until EX lets go
        DONE:
        begin
          if (ex_ready_i)
            state_q <= IDLE;
        end
        default: state_q <= IDLE;
      endcase
    end
  end

  // Sign fix on the full product
  assign product  = neg_result ? -prod_q : prod_q;
  assign result_o = (state_q == DONE) ? ((operator_i == MUL) ? product[31:0] : product[63:32])
                                      : '0;

  // Low from the start cycle until DONE
  assign ready_o = (state_q == DONE) || (state_q == IDLE && !enable_i);

endmodule

// ==== design/ex_pkg.sv ====
package ex_pkg;

  // Data word and register index
  typedef logic [31:0] word_t;
  typedef logic [4:0]  reg_addr_t;

  // Operator set, ALU ops first, then multiply and branch compares
  typedef enum logic [4:0] {
    ADD, SUB, AND, OR, XOR,
    SLL, SRL, SRA,
    SLT, SLTU,
    MUL, MULH, MULHU,
    BEQ, BNE, BLT, BGE
  } op_e;

  // Decoded instruction as presented to the issue register
  typedef struct packed {
    op_e       op;
    reg_addr_t rd;
    reg_addr_t rs1;
    reg_addr_t rs2;
    word_t     imm;       // Operand b when use_imm, branch target otherwise
    logic      use_imm;
  } instr_t;

  // ID/EX pipeline register
  typedef struct packed {
    logic      valid;
    op_e       op;
    reg_addr_t rd;
    word_t     operand_a;
    word_t     operand_b;
    word_t     target;
    logic      alu_en;
    logic      mult_en;
    logic      branch_in_ex;
    logic      rf_we;
  } id_ex_pipe_t;

  // EX/WB pipeline register
  typedef struct packed {
    logic      rf_we;
    reg_addr_t rf_waddr;
    word_t     rf_wdata;
  } ex_wb_pipe_t;

  // One forwarding source back to issue
  typedef struct packed {
    logic      we;
    reg_addr_t waddr;
    word_t     wdata;
  } fwd_t;

endpackage

// ==== design/ex_stage.sv ====
`timescale 1ns/10ps

module ex_stage
#(
  parameter int unsigned MultBitsPerCycle = 2
)
(
  input  logic                clk,
  input  logic                rst_n,

  // ID/EX register
  input  ex_pkg::id_ex_pipe_t id_ex_pipe_i,
  input  logic                wb_ready_i,

  // EX/WB register and forwarding to issue
  output ex_pkg::ex_wb_pipe_t ex_wb_pipe_o,
  output ex_pkg::fwd_t        fwd_ex_o,

  // Branch resolution
  output logic                branch_valid_o,
  output logic                branch_taken_o,
  output ex_pkg::word_t       branch_target_o,

  output logic                ex_ready_o,
  output logic                ex_valid_o
);
  import ex_pkg::*;

  word_t alu_result;
  word_t mult_result;
  word_t ex_wdata;
  logic  alu_cmp_result;
  logic  alu_enable;
  logic  mult_ready;

  // Branches use the ALU comparator only
  assign alu_enable = id_ex_pipe_i.alu_en || id_ex_pipe_i.branch_in_ex;

  //////////////////////////////////////////////////
  // Functional units
  //////////////////////////////////////////////////

  ex_alu alu_i
  (
    .enable_i            ( alu_enable             ),
    .operator_i          ( id_ex_pipe_i.op        ),
    .operand_a_i         ( id_ex_pipe_i.operand_a ),
    .operand_b_i         ( id_ex_pipe_i.operand_b ),
    .result_o            ( alu_result             ),
    .comparison_result_o ( alu_cmp_result         )
  );

  ex_mult
  #(
    .MultBitsPerCycle ( MultBitsPerCycle )
  )
  mult_i
  (
    .clk        ( clk                    ),
    .rst_n      ( rst_n                  ),
    .enable_i   ( id_ex_pipe_i.mult_en   ),
    .operator_i ( id_ex_pipe_i.op        ),
    .op_a_i     ( id_ex_pipe_i.operand_a ),
    .op_b_i     ( id_ex_pipe_i.operand_b ),
    .ex_ready_i ( ex_ready_o             ),
    .result_o   ( mult_result            ),
    .ready_o    ( mult_ready             )
  );

  // Write port mux and forwarding to issue
  always_comb
  begin
    ex_wdata       = id_ex_pipe_i.mult_en ? mult_result : alu_result;
    fwd_ex_o.we    = id_ex_pipe_i.valid && id_ex_pipe_i.rf_we;
    fwd_ex_o.waddr = id_ex_pipe_i.rd;
    fwd_ex_o.wdata = ex_wdata;
  end

  // Branch resolves in its single EX cycle
  assign branch_valid_o  = id_ex_pipe_i.branch_in_ex;
  assign branch_taken_o  = alu_cmp_result;
  assign branch_target_o = id_ex_pipe_i.target;

  // Branch never waits on WB
  assign ex_ready_o = (mult_ready && wb_ready_i) || id_ex_pipe_i.branch_in_ex;
  assign ex_valid_o = (id_ex_pipe_i.alu_en || id_ex_pipe_i.mult_en)
                      && mult_ready && wb_ready_i;

  //////////////////////////////////////////////////
  // EX/WB register
  //////////////////////////////////////////////////

  always_ff @(posedge clk, negedge rst_n)
  begin : ex_wb_register
    if (!rst_n)
      ex_wb_pipe_o <= '0;
    else if (ex_valid_o)
    begin
      ex_wb_pipe_o.rf_we    <= id_ex_pipe_i.rf_we;
      ex_wb_pipe_o.rf_waddr <= id_ex_pipe_i.rd;
      ex_wb_pipe_o.rf_wdata <= ex_wdata;
    end
    // Retired with nothing behind it, drop the write
    else if (wb_ready_i)
      ex_wb_pipe_o.rf_we <= 1'b0;
  end

endmodule

// ==== design/ex_top.sv ====
`timescale 1ns/10ps

module ex_top
#(
  parameter int unsigned MultBitsPerCycle = 2
)
(
  input  logic              clk,
  input  logic              rst_n,

  // Issue side
  input  ex_pkg::instr_t    instr_i,
  input  logic              instr_valid_i,
  output logic              issue_ready_o,

  // Retire side
  input  logic              retire_ready_i,
  output logic              wb_valid_o,
  output ex_pkg::reg_addr_t wb_addr_o,
  output ex_pkg::word_t     wb_data_o,

  // Branch resolution
  output logic              branch_valid_o,
  output logic              branch_taken_o,
  output ex_pkg::word_t     branch_target_o
);
  import ex_pkg::*;

  id_ex_pipe_t id_ex_pipe;
  ex_wb_pipe_t ex_wb_pipe;
  fwd_t        fwd_ex;
  fwd_t        fwd_wb;
  reg_addr_t   rf_raddr_a;
  reg_addr_t   rf_raddr_b;
  word_t       rf_rdata_a;
  word_t       rf_rdata_b;
  logic        ex_ready;
  logic        wb_ready;

  ex_issue issue_i
  (
    .clk           ( clk           ),
    .rst_n         ( rst_n         ),
    .instr_i       ( instr_i       ),
    .instr_valid_i ( instr_valid_i ),
    .issue_ready_o ( issue_ready_o ),
    .ex_ready_i    ( ex_ready      ),
    .fwd_ex_i      ( fwd_ex        ),
    .fwd_wb_i      ( fwd_wb        ),
    .rf_raddr_a_o  ( rf_raddr_a    ),
    .rf_raddr_b_o  ( rf_raddr_b    ),
    .rf_rdata_a_i  ( rf_rdata_a    ),
    .rf_rdata_b_i  ( rf_rdata_b    ),
    .id_ex_pipe_o  ( id_ex_pipe    )
  );

  ex_stage
  #(
    .MultBitsPerCycle ( MultBitsPerCycle )
  )
  ex_stage_i
  (
    .clk             ( clk             ),
    .rst_n           ( rst_n           ),
    .id_ex_pipe_i    ( id_ex_pipe      ),
    .wb_ready_i      ( wb_ready        ),
    .ex_wb_pipe_o    ( ex_wb_pipe      ),
    .fwd_ex_o        ( fwd_ex          ),
    .branch_valid_o  ( branch_valid_o  ),
    .branch_taken_o  ( branch_taken_o  ),
    .branch_target_o ( branch_target_o ),
    .ex_ready_o      ( ex_ready        ),
    // Only used inside EX for the EX/WB load
    .ex_valid_o      (                 )
  );

  ex_wb_stage wb_stage_i
  (
    .clk            ( clk            ),
    .rst_n          ( rst_n          ),
    .ex_wb_pipe_i   ( ex_wb_pipe     ),
    .retire_ready_i ( retire_ready_i ),
    .wb_ready_o     ( wb_ready       ),
    .fwd_wb_o       ( fwd_wb         ),
    .rf_raddr_a_i   ( rf_raddr_a     ),
    .rf_raddr_b_i   ( rf_raddr_b     ),
    .rf_rdata_a_o   ( rf_rdata_a     ),
    .rf_rdata_b_o   ( rf_rdata_b     ),
    .wb_valid_o     ( wb_valid_o     ),
    .wb_addr_o      ( wb_addr_o      ),
    .wb_data_o      ( wb_data_o      )
  );

endmodule

// ==== design/ex_wb_stage.sv ====
`timescale 1ns/10ps

module ex_wb_stage
(
  input  logic                clk,
  input  logic                rst_n,

  input  ex_pkg::ex_wb_pipe_t ex_wb_pipe_i,
  input  logic                retire_ready_i,
  output logic                wb_ready_o,

  // Forwarding to issue
  output ex_pkg::fwd_t        fwd_wb_o,

  // Register file read ports
  input  ex_pkg::reg_addr_t   rf_raddr_a_i,
  input  ex_pkg::reg_addr_t   rf_raddr_b_i,
  output ex_pkg::word_t       rf_rdata_a_o,
  output ex_pkg::word_t       rf_rdata_b_o,

  // Retire strobe
  output logic                wb_valid_o,
  output ex_pkg::reg_addr_t   wb_addr_o,
  output ex_pkg::word_t       wb_data_o
);
  import ex_pkg::*;

  // x1..x31, x0 has no storage
  word_t rf_q [1:31];
  logic  rf_write;

  // Commit when the outside accepts it
  assign rf_write = ex_wb_pipe_i.rf_we && retire_ready_i && (ex_wb_pipe_i.rf_waddr != '0);

  //////////////////////////////////////////////////
  // Register file
  //////////////////////////////////////////////////

  always_ff @(posedge clk, negedge rst_n)
  begin : reg_file
    if (!rst_n)
    begin
      for (int i = 1; i < 32; i++)
        rf_q[i] <= '0;
    end
    else if (rf_write)
      rf_q[ex_wb_pipe_i.rf_waddr] <= ex_wb_pipe_i.rf_wdata;
  end

  // x0 reads as zero
  assign rf_rdata_a_o = (rf_raddr_a_i == '0) ? '0 : rf_q[rf_raddr_a_i];
  assign rf_rdata_b_o = (rf_raddr_b_i == '0) ? '0 : rf_q[rf_raddr_b_i];

  // Pending write still counts as a source until it lands
  assign fwd_wb_o.we    = ex_wb_pipe_i.rf_we;
  assign fwd_wb_o.waddr = ex_wb_pipe_i.rf_waddr;
  assign fwd_wb_o.wdata = ex_wb_pipe_i.rf_wdata;

  // Blocked write stalls EX
  assign wb_ready_o = !ex_wb_pipe_i.rf_we || retire_ready_i;

  assign wb_valid_o = ex_wb_pipe_i.rf_we;
  assign wb_addr_o  = ex_wb_pipe_i.rf_waddr;
  assign wb_data_o  = ex_wb_pipe_i.rf_wdata;

endmodule

// ==== sim.f ====
design/ex_pkg.sv
design/ex_alu.sv
design/ex_mult.sv
design/ex_issue.sv
design/ex_stage.sv
design/ex_wb_stage.sv
design/ex_top.sv
testbench/ex_top_asserts.sv
testbench/tb_ex_top.sv

// ==== testbench/ex_top_asserts.sv ====
`timescale 1ns/10ps

module ex_top_asserts
(
  input logic                clk,
  input logic                rst_n,
  input ex_pkg::id_ex_pipe_t id_ex_pipe,
  input logic                ex_valid,
  input ex_pkg::ex_wb_pipe_t ex_wb_pipe,
  input logic                retire_ready
);
  import ex_pkg::*;

  // One functional unit per instruction
  unit_exclusive: assert property (@(posedge clk) disable iff (!rst_n)
    !(id_ex_pipe.alu_en && id_ex_pipe.mult_en))
    else $error("alu_en and mult_en high together");

  // x0 has no storage
  no_x0_write: assert property (@(posedge clk) disable iff (!rst_n)
    !(ex_wb_pipe.rf_we && retire_ready && (ex_wb_pipe.rf_waddr == '0)))
    else $error("register 0 written");

  // Blocked retire keeps EX/WB frozen
  wb_hold: assert property (@(posedge clk) disable iff (!rst_n)
    (ex_wb_pipe.rf_we && !retire_ready) |=> $stable(ex_wb_pipe))
    else $error("EX/WB changed while retire was blocked");

  // Branch never loads EX/WB
  branch_no_wb: assert property (@(posedge clk) disable iff (!rst_n)
    id_ex_pipe.branch_in_ex |-> (!ex_valid && !id_ex_pipe.rf_we))
    else $error("branch produced a writeback");

endmodule

// EX side checks, WB inputs tied off
bind ex_stage ex_top_asserts stage_asserts
(
  .clk          ( clk          ),
  .rst_n        ( rst_n        ),
  .id_ex_pipe   ( id_ex_pipe_i ),
  .ex_valid     ( ex_valid_o   ),
  .ex_wb_pipe   ( '0           ),
  .retire_ready ( 1'b1         )
);

// WB side checks, EX inputs tied off
bind ex_wb_stage ex_top_asserts wb_asserts
(
  .clk          ( clk            ),
  .rst_n        ( rst_n          ),
  .id_ex_pipe   ( '0             ),
  .ex_valid     ( 1'b0           ),
  .ex_wb_pipe   ( ex_wb_pipe_i   ),
  .retire_ready ( retire_ready_i )
);

// ==== testbench/tb_ex_top.sv ====
`timescale 1ns/10ps

module tb_ex_top;
  import ex_pkg::*;

  // Instructions issued over all tests
  localparam int unsigned num_instr      = 56;
  localparam int unsigned timeout_cycles = num_instr * 24;
  localparam int unsigned mult_bits      = 2;
  localparam int unsigned mult_cycles    = 32 / mult_bits;

  logic      clk;
  logic      rst_n;
  instr_t    instr_i;
  logic      instr_valid_i;
  logic      issue_ready_o;
  logic      retire_ready_i;
  logic      wb_valid_o;
  reg_addr_t wb_addr_o;
  word_t     wb_data_o;
  logic      branch_valid_o;
  logic      branch_taken_o;
  word_t     branch_target_o;

  // Model register file and the writes still expected in order
  word_t       mrf [32];
  reg_addr_t   exp_addr_q [$];
  word_t       exp_data_q [$];
  logic [15:0] lfsr_q;
  int unsigned cycle_cnt = 0;

  ex_top
  #(
    .MultBitsPerCycle ( mult_bits )
  )
  dut0
  (
    .clk             ( clk             ),
    .rst_n           ( rst_n           ),
    .instr_i         ( instr_i         ),
    .instr_valid_i   ( instr_valid_i   ),
    .issue_ready_o   ( issue_ready_o   ),
    .retire_ready_i  ( retire_ready_i  ),
    .wb_valid_o      ( wb_valid_o      ),
    .wb_addr_o       ( wb_addr_o       ),
    .wb_data_o       ( wb_data_o       ),
    .branch_valid_o  ( branch_valid_o  ),
    .branch_taken_o  ( branch_taken_o  ),
    .branch_target_o ( branch_target_o )
  );

  always #5 clk = ~clk;

  //////////////////////////////////////////////////
  // Failure reporting and compares
  //////////////////////////////////////////////////

  task automatic stop_with_failure(string why);
    $display("%s", why);
    $display("*** FAILED ***");
    $fatal(1, "Simulation stopped on error");
  endtask

  task automatic check_word(string name, word_t exp, word_t act);
    if (exp !== act)
      stop_with_failure($sformatf("Error at %0t ns: %s expected %h, got %h",
                                  $time, name, exp, act));
  endtask

  task automatic check_addr(string name, reg_addr_t exp, reg_addr_t act);
    if (exp !== act)
      stop_with_failure($sformatf("Error at %0t ns: %s expected %0d, got %0d",
                                  $time, name, exp, act));
  endtask

  task automatic check_bit(string name, logic exp, logic act);
    if (exp !== act)
      stop_with_failure($sformatf("Error at %0t ns: %s expected %b, got %b",
                                  $time, name, exp, act));
  endtask

  //////////////////////////////////////////////////
  // LFSR and reference model
  //////////////////////////////////////////////////

  // 16 bit Fibonacci LFSR with taps 16 14 13 11
  function automatic logic lfsr_bit();
    logic out_bit;
    out_bit = lfsr_q[15];
    lfsr_q  = {lfsr_q[14:0], lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10]};
    return out_bit;
  endfunction

  function automatic word_t rand_word();
    word_t w;
    w = '0;
    for (int i = 0; i < 32; i++)
      w = {w[30:0], lfsr_bit()};
    return w;
  endfunction

  function automatic logic is_branch(op_e op);
    return op inside {BEQ, BNE, BLT, BGE};
  endfunction

  // Expected write value per RISC-V semantics
  function automatic word_t ref_result(op_e op, word_t a, word_t b);
    longint      sa;
    longint      sb;
    logic [63:0] p;
    sa = longint'($signed(a));
    sb = longint'($signed(b));
    case (op)
      ADD:     return a + b;
      SUB:     return a - b;
      AND:     return a & b;
      OR:      return a | b;
      XOR:     return a ^ b;
      SLL:     return a << b[4:0];
      SRL:     return a >> b[4:0];
      SRA:     return word_t'($signed(a) >>> b[4:0]);
      SLT:     return (sa < sb) ? 32'd1 : 32'd0;
      SLTU:    return (a < b) ? 32'd1 : 32'd0;
      MUL:     return a * b;
      MULH:
      begin
        p = sa * sb;
        return p[63:32];
      end
      MULHU:
      begin
        p = {32'b0, a} * {32'b0, b};
        return p[63:32];
      end
      default: return '0;
    endcase
  endfunction

  function automatic logic ref_taken(op_e op, word_t a, word_t b);
    case (op)
      BEQ:     return a == b;
      BNE:     return a != b;
      BLT:     return $signed(a) < $signed(b);
      BGE:     return $signed(a) >= $signed(b);
      default: return 1'b0;
    endcase
  endfunction

  function automatic instr_t make_instr(op_e op, reg_addr_t rd, reg_addr_t rs1,
                                        reg_addr_t rs2, word_t imm, logic use_imm);
    instr_t ins;
    ins.op      = op;
    ins.rd      = rd;
    ins.rs1     = rs1;
    ins.rs2     = rs2;
    ins.imm     = imm;
    ins.use_imm = use_imm;
    return ins;
  endfunction

  //////////////////////////////////////////////////
  // Driving and monitoring
  //////////////////////////////////////////////////

  // Runs from a falling edge to the falling edge after the take
  task automatic issue(instr_t ins);
    word_t a;
    word_t b;
    word_t res;
    instr_i       = ins;
    instr_valid_i = 1'b1;
    #1;
    while (!issue_ready_o)
    begin
      @(negedge clk);
      #1;
    end
    // Model moves in program order as the next rising edge takes it
    a = mrf[ins.rs1];
    b = ins.use_imm ? ins.imm : mrf[ins.rs2];
    if (!is_branch(ins.op) && (ins.rd != '0))
    begin
      res          = ref_result(ins.op, a, b);
      mrf[ins.rd]  = res;
      exp_addr_q.push_back(ins.rd);
      exp_data_q.push_back(res);
    end
    @(negedge clk);
    instr_valid_i = 1'b0;
    instr_i       = '0;
  endtask

  task automatic wait_retired();
    while (exp_addr_q.size() != 0)
      @(negedge clk);
    repeat (2) @(negedge clk);
  endtask

  // Every committed write must be the oldest one expected
  always @(posedge clk)
  begin : wb_monitor
    reg_addr_t ea;
    word_t     ed;
    if (rst_n && wb_valid_o && retire_ready_i)
    begin
      if (exp_addr_q.size() == 0)
        stop_with_failure("A writeback was retired that no instruction should produce");
      else
      begin
        ea = exp_addr_q.pop_front();
        ed = exp_data_q.pop_front();
        check_addr("wb_addr_o", ea, wb_addr_o);
        check_word("wb_data_o", ed, wb_data_o);
      end
    end
  end

  always @(posedge clk)
  begin : watchdog
    cycle_cnt++;
    if (cycle_cnt > timeout_cycles)
      stop_with_failure("The run took too long, the pipeline seems to be stuck");
  end

  //////////////////////////////////////////////////
  // Directed tests
  //////////////////////////////////////////////////

  // Each ALU op in register and immediate form over 22 instructions
  task automatic test_alu_ops();
    op_e   ops [10];
    word_t imm;
    ops = '{ADD, SUB, AND, OR, XOR, SLL, SRL, SRA, SLT, SLTU};
    issue(make_instr(ADD, 5'd1, 5'd0, 5'd0, rand_word(), 1'b1));
    issue(make_instr(ADD, 5'd2, 5'd0, 5'd0, rand_word() | 32'h8000_0000, 1'b1));
    wait_retired();
    foreach (ops[i])
    begin
      issue(make_instr(ops[i], 5'd5, 5'd1, 5'd2, '0, 1'b0));
      check_bit("wb_valid_o", 1'b0, wb_valid_o);
      @(negedge clk);
      // Result shows two cycles after issue
      check_bit("wb_valid_o", 1'b1, wb_valid_o);
      check_addr("wb_addr_o", 5'd5, wb_addr_o);
      check_word("wb_data_o", mrf[5], wb_data_o);
      imm = rand_word();
      issue(make_instr(ops[i], 5'd6, 5'd2, 5'd0, imm, 1'b1));
      check_bit("wb_valid_o", 1'b0, wb_valid_o);
      @(negedge clk);
      check_bit("wb_valid_o", 1'b1, wb_valid_o);
      check_addr("wb_addr_o", 5'd6, wb_addr_o);
      check_word("wb_data_o", mrf[6], wb_data_o);
    end
    wait_retired();
  endtask

  // Seven back to back dependent instructions through EX, WB and the file
  task automatic test_forwarding();
    issue(make_instr(ADD, 5'd7,  5'd1,  5'd2,  '0, 1'b0));
    issue(make_instr(XOR, 5'd8,  5'd7,  5'd1,  '0, 1'b0));
    issue(make_instr(SUB, 5'd9,  5'd8,  5'd7,  '0, 1'b0));
    issue(make_instr(OR,  5'd10, 5'd9,  5'd7,  '0, 1'b0));
    // x0 takes no write and keeps reading zero
    issue(make_instr(ADD, 5'd0,  5'd1,  5'd0,  rand_word(), 1'b1));
    issue(make_instr(ADD, 5'd11, 5'd0,  5'd10, '0, 1'b0));
    issue(make_instr(ADD, 5'd12, 5'd0,  5'd0,  '0, 1'b0));
    wait_retired();
  endtask

  // Twelve instructions of multiply ops on mixed sign operands
  task automatic test_multiply();
    op_e         ops [3];
    reg_addr_t   src_a [3];
    reg_addr_t   src_b [3];
    int unsigned low_cnt;
    ops   = '{MUL, MULH, MULHU};
    src_a = '{5'd14, 5'd15, 5'd16};
    src_b = '{5'd15, 5'd15, 5'd14};
    issue(make_instr(ADD, 5'd14, 5'd0, 5'd0, rand_word(), 1'b1));
    issue(make_instr(ADD, 5'd15, 5'd0, 5'd0, rand_word() | 32'h8000_0000, 1'b1));
    issue(make_instr(ADD, 5'd16, 5'd0, 5'd0, rand_word() & 32'h7fff_ffff, 1'b1));
    wait_retired();
    foreach (ops[i])
    begin
      foreach (src_a[j])
      begin
        issue(make_instr(ops[i], 5'd13, src_a[j], src_b[j], '0, 1'b0));
        low_cnt = 0;
        while (!issue_ready_o)
        begin
          low_cnt++;
          @(negedge clk);
        end
        check_word("issue_ready_o low cycles", word_t'(mult_cycles), word_t'(low_cnt));
      end
    end
    wait_retired();
  endtask

  // Eleven instructions of branch compares in EX with no writeback
  task automatic test_branches();
    op_e       ops [4];
    reg_addr_t src_a [2];
    reg_addr_t src_b [2];
    word_t     target;
    logic      taken;
    ops   = '{BEQ, BNE, BLT, BGE};
    src_a = '{5'd17, 5'd19};
    src_b = '{5'd18, 5'd17};
    issue(make_instr(ADD, 5'd17, 5'd0,  5'd0, rand_word(), 1'b1));
    issue(make_instr(ADD, 5'd18, 5'd17, 5'd0, '0, 1'b1));
    issue(make_instr(ADD, 5'd19, 5'd0,  5'd0, rand_word() | 32'h8000_0000, 1'b1));
    wait_retired();
    foreach (ops[i])
    begin
      foreach (src_a[j])
      begin
        target = rand_word();
        taken  = ref_taken(ops[i], mrf[src_a[j]], mrf[src_b[j]]);
        // A branch with a nonzero rd must still not write
        issue(make_instr(ops[i], 5'd20, src_a[j], src_b[j], target, 1'b1));
        check_bit("branch_valid_o", 1'b1, branch_valid_o);
        check_bit("branch_taken_o", taken, branch_taken_o);
        check_word("branch_target_o", target, branch_target_o);
        @(negedge clk);
        check_bit("branch_valid_o", 1'b0, branch_valid_o);
      end
    end
    wait_retired();
  endtask

  // Four instructions where a retire stall holds WB and blocks issue
  task automatic test_backpressure();
    retire_ready_i = 1'b0;
    issue(make_instr(ADD, 5'd21, 5'd1,  5'd0,  rand_word(), 1'b1));
    issue(make_instr(ADD, 5'd22, 5'd21, 5'd2,  '0, 1'b0));
    check_bit("wb_valid_o", 1'b1, wb_valid_o);
    check_bit("issue_ready_o", 1'b0, issue_ready_o);
    check_addr("wb_addr_o", 5'd21, wb_addr_o);
    check_word("wb_data_o", mrf[21], wb_data_o);
    repeat (5)
    begin
      @(negedge clk);
      check_bit("wb_valid_o", 1'b1, wb_valid_o);
      check_addr("wb_addr_o", 5'd21, wb_addr_o);
      check_word("wb_data_o", mrf[21], wb_data_o);
      check_bit("issue_ready_o", 1'b0, issue_ready_o);
    end
    retire_ready_i = 1'b1;
    issue(make_instr(XOR, 5'd23, 5'd22, 5'd21, '0, 1'b0));
    issue(make_instr(SUB, 5'd24, 5'd23, 5'd1,  '0, 1'b0));
    wait_retired();
  endtask

  //////////////////////////////////////////////////
  // Main sequence
  //////////////////////////////////////////////////

  initial
  begin
    clk            = 1'b0;
    rst_n          = 1'b0;
    instr_i        = '0;
    instr_valid_i  = 1'b0;
    retire_ready_i = 1'b1;
    lfsr_q         = 16'd19;
    foreach (mrf[i])
      mrf[i] = '0;

    repeat (4) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);
    check_bit("issue_ready_o", 1'b1, issue_ready_o);
    check_bit("wb_valid_o", 1'b0, wb_valid_o);
    check_bit("branch_valid_o", 1'b0, branch_valid_o);

    test_alu_ops();
    test_forwarding();
    test_multiply();
    test_branches();
    test_backpressure();

    $display("*** PASSED ***");
    $finish;
  end

endmodule
